/* tb.f */
source/dcache_pkg.sv
source/load_port_adapter.sv
source/store_amo_adapter.sv
source/dcache_req_arbiter.sv
source/dcache_core.sv
source/dcache_top.sv
bench/tb_clock_gen.sv
bench/dcache_checker.sv
bench/tb_dcache_top.sv

/* run.sh */
#!/bin/sh
# Build and run the testbench; exit status reflects the result
verilator --binary --timing --assert -f tb.f --top-module tb_dcache_top -o tb_sim \
  && ./obj_dir/tb_sim \
  || exit 1

/* bench/tb_dcache_top.sv */
module tb_dcache_top;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int TIMEOUT_CYCLES = 20000;

  logic                   clk;
  logic                   rst_n;
  logic                   load_valid_i;
  dcache_pkg::load_req_t  load_req_i;
  logic                   load_ready_o;
  logic                   load_rsp_valid_o;
  dcache_pkg::load_rsp_t  load_rsp_o;
  logic                   store_valid_i;
  dcache_pkg::store_req_t store_req_i;
  logic                   store_ready_o;
  logic                   amo_req_valid_i;
  dcache_pkg::amo_req_t   amo_req_i;
  logic                   amo_ack_o;
  dcache_pkg::data_t      amo_result_o;

  integer seed = 32'hff4d;
  int     cycle = 0;

  // Reference memory and reservation
  dcache_pkg::data_t   ref_mem [dcache_pkg::NUM_LINES];
  logic                resv_valid = 1'b0;
  dcache_pkg::offset_t resv_off = '0;

  dcache_pkg::data_t exp_ld_data [$];
  dcache_pkg::tid_t  exp_ld_tid [$];
  int                exp_ld_cycle [$];
  dcache_pkg::data_t exp_amo_data;
  int                exp_amo_cycle;
  logic              amo_issued = 1'b0;
  logic              ack_seen = 1'b0;
  logic              ld_fire = 1'b0;
  logic              st_fire = 1'b0;

  tb_clock_gen clock0 (.clk_o(clk), .rst_n_o(rst_n));

  dcache_top dut0 (
    .clk_i            (clk),
    .rst_n_i          (rst_n),
    .load_valid_i     (load_valid_i),
    .load_req_i       (load_req_i),
    .load_ready_o     (load_ready_o),
    .load_rsp_valid_o (load_rsp_valid_o),
    .load_rsp_o       (load_rsp_o),
    .store_valid_i    (store_valid_i),
    .store_req_i      (store_req_i),
    .store_ready_o    (store_ready_o),
    .amo_req_valid_i  (amo_req_valid_i),
    .amo_req_i        (amo_req_i),
    .amo_ack_o        (amo_ack_o),
    .amo_result_o     (amo_result_o)
  );

  bind store_amo_adapter dcache_checker checker0 (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .amo_req_valid_i (amo_req_valid_i),
    .req_valid_o     (req_valid_o),
    .req_ready_i     (req_ready_i),
    .req_o           (req_o),
    .amo_ack_o       (amo_ack_o),
    .pending_q       (pending_q)
  );

  task automatic abort_run();
    $display("TB FAILED");
    $fatal(1, "stopping after first error");
  endtask

  task automatic check_value(input string name, input logic [63:0] exp,
                             input logic [63:0] act);
    if (exp !== act) begin
      $display("FAIL %s expected %h actual %h", name, exp, act);
      abort_run();
    end
  endtask

  function automatic logic [31:0] rand32();
    rand32 = $random(seed);
  endfunction

  function automatic dcache_pkg::data_t sext32(input logic [31:0] w);
    return {{32{w[31]}}, w};
  endfunction

  task automatic model_store(input dcache_pkg::store_req_t req);
    dcache_pkg::offset_t off;
    off = req.addr[10:3];
    for (int b = 0; b < 8; b++) begin
      if (req.be[b]) ref_mem[off][8*b +: 8] = req.wdata[8*b +: 8];
    end
    resv_valid = 1'b0;
  endtask

  // Returns the value the core should see on the ack
  task automatic model_amo(input dcache_pkg::amo_req_t req, output dcache_pkg::data_t res);
    dcache_pkg::offset_t off;
    logic                word;
    logic                hi;
    logic                wr;
    logic [31:0]         lane;
    dcache_pkg::data_t   old;
    dcache_pkg::data_t   a;
    dcache_pkg::data_t   b;
    dcache_pkg::data_t   nv;
    off  = req.operand_a[10:3];
    word = (req.size == 2'd2);
    hi   = word && req.operand_a[2];
    old  = ref_mem[off];
    lane = hi ? old[63:32] : old[31:0];
    a    = word ? sext32(lane) : old;
    b    = word ? sext32(req.operand_b[31:0]) : req.operand_b;
    res  = a;
    wr   = 1'b1;
    nv   = b;
    case (req.op)
      dcache_pkg::AMO_LR: begin
        wr = 1'b0;
        resv_off = off;
      end
      dcache_pkg::AMO_SC: begin
        wr  = resv_valid && (resv_off == off);
        res = wr ? 64'd0 : 64'd1;
      end
      dcache_pkg::AMO_ADD:  nv = a + b;
      dcache_pkg::AMO_AND:  nv = a & b;
      dcache_pkg::AMO_OR:   nv = a | b;
      dcache_pkg::AMO_XOR:  nv = a ^ b;
      dcache_pkg::AMO_MAX:  nv = ($signed(a) > $signed(b)) ? a : b;
      dcache_pkg::AMO_MAXU: nv = (a > b) ? a : b;
      dcache_pkg::AMO_MIN:  nv = ($signed(a) < $signed(b)) ? a : b;
      dcache_pkg::AMO_MINU: nv = (a < b) ? a : b;
      default: ;
    endcase
    resv_valid = (req.op == dcache_pkg::AMO_LR);
    if (wr) begin
      if (!word) ref_mem[off] = nv;
      else if (hi) ref_mem[off][63:32] = nv[31:0];
      else ref_mem[off][31:0] = nv[31:0];
    end
  endtask

  // Acceptance and responses are looked at mid-cycle where all are stable
  always @(negedge clk) begin
    dcache_pkg::data_t res;
    if (rst_n) begin
      ld_fire = load_valid_i && load_ready_o;
      st_fire = store_valid_i && store_ready_o;
      if (load_valid_i) check_value("load ready", 64'd1, 64'(load_ready_o));
      if (load_valid_i) check_value("store ready under load", 64'd0, 64'(store_ready_o));
      if (ld_fire) begin
        exp_ld_data.push_back(ref_mem[load_req_i.addr[10:3]]);
        exp_ld_tid.push_back(load_req_i.tid);
        exp_ld_cycle.push_back(cycle + 2);
      end
      if (st_fire) model_store(store_req_i);
      if (amo_req_valid_i && !amo_issued && !load_valid_i) begin
        model_amo(amo_req_i, res);
        exp_amo_data  = res;
        exp_amo_cycle = cycle + 2;
        amo_issued    = 1'b1;
      end
      if (load_rsp_valid_o) begin
        if (exp_ld_data.size() == 0) begin
          $display("ERROR: load response with no load outstanding");
          abort_run();
        end
        check_value("load data", exp_ld_data.pop_front(), load_rsp_o.rdata);
        check_value("load tid", 64'(exp_ld_tid.pop_front()), 64'(load_rsp_o.tid));
        check_value("load latency", 64'(exp_ld_cycle.pop_front()), 64'(cycle));
      end
      if (amo_ack_o) begin
        if (!amo_issued) begin
          $display("ERROR: AMO ack with no AMO outstanding");
          abort_run();
        end
        check_value("amo result", exp_amo_data, amo_result_o);
        check_value("amo latency", 64'(exp_amo_cycle), 64'(cycle));
        amo_issued = 1'b0;
        ack_seen   = 1'b1;
      end
    end
  end

  always @(posedge clk) begin
    cycle++;
    if (cycle >= TIMEOUT_CYCLES) begin
      $display("ERROR: timeout, run did not finish within %0d cycles", TIMEOUT_CYCLES);
      abort_run();
    end
  end

  function automatic dcache_pkg::load_req_t random_load(input dcache_pkg::offset_t off);
    dcache_pkg::load_req_t req;
    logic [31:0]           r;
    r        = rand32();
    req.addr = {off, 3'b000};
    req.size = 2'd3;
    req.be   = 8'hff;
    req.tid  = r[3:0];
    return req;
  endfunction

  function automatic dcache_pkg::store_req_t random_store(input dcache_pkg::offset_t off);
    dcache_pkg::store_req_t req;
    logic [31:0]            r;
    r         = rand32();
    req.addr  = {off, r[2:0]};
    req.wdata = {rand32(), rand32()};
    req.be    = r[15:8];
    req.size  = 2'd3;
    return req;
  endfunction

  // Loads are always taken at once, stores hold until accepted
  task automatic run_traffic(input int cycles, input int load_pct, input int store_pct,
                             input logic [7:0] off_mask);
    logic keep_st;
    for (int i = 0; i < cycles; i++) begin
      @(posedge clk);
      load_valid_i <= (rand32() % 100) < 32'(load_pct);
      load_req_i   <= random_load(8'(rand32()) & off_mask);
      if (st_fire || !store_valid_i) begin
        store_valid_i <= (rand32() % 100) < 32'(store_pct);
        store_req_i   <= random_store(8'(rand32()) & off_mask);
      end
    end
    @(posedge clk);
    load_valid_i <= 1'b0;
    keep_st = store_valid_i && !st_fire;
    if (!keep_st) store_valid_i <= 1'b0;
    while (keep_st) begin
      @(posedge clk);
      keep_st = !st_fire;
      if (!keep_st) store_valid_i <= 1'b0;
    end
  endtask

  task automatic issue_load(input dcache_pkg::offset_t off);
    @(posedge clk);
    load_valid_i <= 1'b1;
    load_req_i   <= random_load(off);
    @(posedge clk);
    load_valid_i <= 1'b0;
  endtask

  task automatic issue_store(input dcache_pkg::offset_t off);
    @(posedge clk);
    store_valid_i <= 1'b1;
    store_req_i   <= random_store(off);
    do @(posedge clk); while (!st_fire);
    store_valid_i <= 1'b0;
  endtask

  task automatic do_amo(input logic [3:0] op, input dcache_pkg::size_t size,
                        input dcache_pkg::addr_t addr, input dcache_pkg::data_t opb);
    dcache_pkg::amo_req_t req;
    req.op        = dcache_pkg::amo_op_e'(op);
    req.size      = size;
    req.operand_a = addr;
    req.operand_b = opb;
    @(posedge clk);
    amo_req_valid_i <= 1'b1;
    amo_req_i       <= req;
    do @(posedge clk); while (!ack_seen);
    ack_seen = 1'b0;
    amo_req_valid_i <= 1'b0;
  endtask

  initial begin
    dcache_pkg::offset_t off;
    logic [31:0]         r;
    logic                word;
    load_valid_i    = 1'b0;
    load_req_i      = '0;
    store_valid_i   = 1'b0;
    store_req_i     = '0;
    amo_req_valid_i = 1'b0;
    amo_req_i       = '0;
    for (int i = 0; i < dcache_pkg::NUM_LINES; i++) ref_mem[i] = '0;
    wait (rst_n);

    run_traffic(800, 70, 0, 8'hff);
    run_traffic(1500, 40, 50, 8'h1f);

    // Doubleword AMOs, SWAP through MINU
    for (int i = 0; i < 120; i++) begin
      r   = rand32();
      off = r[7:0];
      do_amo(4'(2 + (r[31:8] % 9)), 2'd3, {off, 3'b000}, {rand32(), rand32()});
      issue_load(off);
    end

    // Word AMOs in both lanes
    for (int i = 0; i < 120; i++) begin
      r   = rand32();
      off = r[7:0];
      do_amo(4'(2 + (r[31:9] % 9)), 2'd2, {off, r[8], 2'b00}, {rand32(), rand32()});
      issue_load(off);
    end

    // LR/SC pairs, clean, broken by a store, or to another line
    for (int i = 0; i < 40; i++) begin
      r    = rand32();
      off  = r[7:0];
      word = r[8];
      do_amo(4'(dcache_pkg::AMO_LR), word ? 2'd2 : 2'd3, {off, word & r[9], 2'b00}, '0);
      if (r[11:10] == 2'd1) issue_store(8'(rand32()));
      if (r[11:10] == 2'd2) off = off + 8'd1;
      do_amo(4'(dcache_pkg::AMO_SC), word ? 2'd2 : 2'd3, {off, word & r[9], 2'b00},
             {rand32(), rand32()});
      issue_load(off);
    end

    run_traffic(1000, 60, 80, 8'h0f);

    for (int i = 0; i < dcache_pkg::NUM_LINES; i++) issue_load(8'(i));

    // Responses come two cycles after acceptance
    repeat (4) @(negedge clk);
    if (exp_ld_data.size() != 0 || amo_issued) begin
      $display("ERROR: responses still outstanding at end of test");
      abort_run();
    end else begin
      $display("TB PASSED");
      $finish;
    end
  end

endmodule

/* bench/dcache_checker.sv */
module dcache_checker (
  input logic                   clk_i,
  input logic                   rst_n_i,
  input logic                   amo_req_valid_i,
  input logic                   req_valid_o,
  input logic                   req_ready_i,
  input dcache_pkg::cache_req_t req_o,
  input logic                   amo_ack_o,
  input logic                   pending_q
);

  timeunit 1ns;
  timeprecision 1ps;

  // An ack only closes an AMO that is in flight
  a_ack_while_pending: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    amo_ack_o |-> pending_q)
    else $error("AMO ack seen with no AMO pending");

  // No second issue of the same AMO before its ack
  a_single_issue: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (pending_q && amo_req_valid_i) |->
      !(req_valid_o && req_ready_i && req_o.tid == dcache_pkg::AMO_TID))
    else $error("AMO issued again while still pending");

  // Stalled request keeps its payload
  a_stable_when_stalled: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (req_valid_o && !req_ready_i) |=> (req_valid_o && $stable(req_o)))
    else $error("Request dropped or changed while stalled");

endmodule

/* bench/tb_clock_gen.sv */
module tb_clock_gen (
  output logic clk_o,
  output logic rst_n_o
);

  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  // Reset held low for the first 8 rising edges
  initial begin
    rst_n_o = 1'b0;
    repeat (8) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

/* source/dcache_top.sv */
module dcache_top (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   load_valid_i,
  input  dcache_pkg::load_req_t  load_req_i,
  output logic                   load_ready_o,
  output logic                   load_rsp_valid_o,
  output dcache_pkg::load_rsp_t  load_rsp_o,
  input  logic                   store_valid_i,
  input  dcache_pkg::store_req_t store_req_i,
  output logic                   store_ready_o,
  input  logic                   amo_req_valid_i,
  input  dcache_pkg::amo_req_t   amo_req_i,
  output logic                   amo_ack_o,
  output dcache_pkg::data_t      amo_result_o
);

  logic                   ld_valid;
  logic                   ld_ready;
  dcache_pkg::cache_req_t ld_req;
  logic                   st_valid;
  logic                   st_ready;
  dcache_pkg::cache_req_t st_req;
  logic                   cache_req_valid;
  logic                   cache_req_ready;
  dcache_pkg::cache_req_t cache_req;
  logic                   cache_rsp_valid;
  dcache_pkg::cache_rsp_t cache_rsp;
  logic                   port_rsp_valid;
  dcache_pkg::cache_rsp_t port_rsp;

  load_port_adapter load_adapter0 (
    .load_valid_i     (load_valid_i),
    .load_req_i       (load_req_i),
    .load_ready_o     (load_ready_o),
    .load_rsp_valid_o (load_rsp_valid_o),
    .load_rsp_o       (load_rsp_o),
    .req_valid_o      (ld_valid),
    .req_ready_i      (ld_ready),
    .req_o            (ld_req),
    .rsp_valid_i      (port_rsp_valid),
    .rsp_i            (port_rsp)
  );

  store_amo_adapter store_adapter0 (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .store_valid_i   (store_valid_i),
    .store_req_i     (store_req_i),
    .store_ready_o   (store_ready_o),
    .amo_req_valid_i (amo_req_valid_i),
    .amo_req_i       (amo_req_i),
    .amo_ack_o       (amo_ack_o),
    .amo_result_o    (amo_result_o),
    .req_valid_o     (st_valid),
    .req_ready_i     (st_ready),
    .req_o           (st_req),
    .rsp_valid_i     (port_rsp_valid),
    .rsp_i           (port_rsp)
  );

  dcache_req_arbiter arbiter0 (
    .load_valid_i  (ld_valid),
    .load_req_i    (ld_req),
    .load_ready_o  (ld_ready),
    .store_valid_i (st_valid),
    .store_req_i   (st_req),
    .store_ready_o (st_ready),
    .req_valid_o   (cache_req_valid),
    .req_o         (cache_req),
    .req_ready_i   (cache_req_ready),
    .rsp_valid_i   (cache_rsp_valid),
    .rsp_i         (cache_rsp),
    .rsp_valid_o   (port_rsp_valid),
    .rsp_o         (port_rsp)
  );

  dcache_core cache0 (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_valid_i (cache_req_valid),
    .req_i       (cache_req),
    .req_ready_o (cache_req_ready),
    .rsp_valid_o (cache_rsp_valid),
    .rsp_o       (cache_rsp)
  );

endmodule

/* source/dcache_core.sv */
module dcache_core (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   req_valid_i,
  input  dcache_pkg::cache_req_t req_i,
  output logic                   req_ready_o,
  output logic                   rsp_valid_o,
  output dcache_pkg::cache_rsp_t rsp_o
);

  dcache_pkg::data_t     mem [dcache_pkg::NUM_LINES];
  logic                  accept;
  logic                  is_word;
  logic                  lane_hi;
  logic                  sc_ok;
  logic                  write_en;
  dcache_pkg::data_t     old_dw;
  dcache_pkg::data_t     be_mask;
  dcache_pkg::data_t     op_a;
  dcache_pkg::data_t     op_b;
  dcache_pkg::data_t     amo_res;
  dcache_pkg::data_t     new_dw;
  dcache_pkg::data_t     merged_dw;
  dcache_pkg::data_t     rsp_data;
  logic                  resv_valid_q;
  dcache_pkg::offset_t   resv_offset_q;
  logic                  stage_valid_q;
  dcache_pkg::cache_rsp_t stage_rsp_q;

  // No miss path, so every request is taken at once
  assign req_ready_o = 1'b1;
  assign accept      = req_valid_i & req_ready_o;

  assign old_dw  = mem[req_i.offset];
  assign is_word = (req_i.size == dcache_pkg::SIZE_WORD);
  assign lane_hi = req_i.be[4];
  assign sc_ok   = resv_valid_q && (resv_offset_q == req_i.offset);

  always_comb begin
    for (int i = 0; i < $bits(dcache_pkg::be_t); i++) begin
      be_mask[8*i +: 8] = {8{req_i.be[i]}};
    end
  end

  // Word operands are sign-extended from the active lane
  always_comb begin
    if (!is_word) begin
      op_a = old_dw;
      op_b = req_i.wdata;
    end else if (lane_hi) begin
      op_a = {{32{old_dw[63]}}, old_dw[63:32]};
      op_b = {{32{req_i.wdata[63]}}, req_i.wdata[63:32]};
    end else begin
      op_a = {{32{old_dw[31]}}, old_dw[31:0]};
      op_b = {{32{req_i.wdata[31]}}, req_i.wdata[31:0]};
    end
  end

  // AMO arithmetic
  always_comb begin
    case (req_i.op)
      dcache_pkg::CACHE_AMO_ADD:  amo_res = op_a + op_b;
      dcache_pkg::CACHE_AMO_AND:  amo_res = op_a & op_b;
      dcache_pkg::CACHE_AMO_OR:   amo_res = op_a | op_b;
      dcache_pkg::CACHE_AMO_XOR:  amo_res = op_a ^ op_b;
      dcache_pkg::CACHE_AMO_MAX:  amo_res = ($signed(op_a) > $signed(op_b)) ? op_a : op_b;
      dcache_pkg::CACHE_AMO_MAXU: amo_res = (op_a > op_b) ? op_a : op_b;
      dcache_pkg::CACHE_AMO_MIN:  amo_res = ($signed(op_a) < $signed(op_b)) ? op_a : op_b;
      dcache_pkg::CACHE_AMO_MINU: amo_res = (op_a < op_b) ? op_a : op_b;
      default:                    amo_res = op_b;
    endcase
  end

  always_comb begin
    if (req_i.op == dcache_pkg::CACHE_STORE || req_i.op == dcache_pkg::CACHE_AMO_SC) begin
      new_dw = req_i.wdata;
    end else begin
      new_dw = is_word ? {2{amo_res[31:0]}} : amo_res;
    end
    merged_dw = (new_dw & be_mask) | (old_dw & ~be_mask);

    case (req_i.op)
      dcache_pkg::CACHE_LOAD,
      dcache_pkg::CACHE_AMO_LR: write_en = 1'b0;
      dcache_pkg::CACHE_AMO_SC: write_en = sc_ok;
      default:                  write_en = 1'b1;
    endcase

    // SC reports 0 on success and 1 on failure
    if (req_i.op == dcache_pkg::CACHE_AMO_SC) begin
      rsp_data = is_word ? {2{31'b0, ~sc_ok}} : {63'b0, ~sc_ok};
    end else begin
      rsp_data = old_dw;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < dcache_pkg::NUM_LINES; i++) begin
        mem[i] <= '0;
      end
    end else if (accept && write_en) begin
      mem[req_i.offset] <= merged_dw;
    end
  end

  // Reservation is set by LR and dropped by any write-type access
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      resv_valid_q <= 1'b0;
    end else if (accept && req_i.op == dcache_pkg::CACHE_AMO_LR) begin
      resv_valid_q <= 1'b1;
    end else if (accept && req_i.op != dcache_pkg::CACHE_LOAD) begin
      resv_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept && req_i.op == dcache_pkg::CACHE_AMO_LR) begin
      resv_offset_q <= req_i.offset;
    end
  end

  // Two-stage response, out in the cycle after the next edge
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      stage_valid_q <= 1'b0;
      rsp_valid_o   <= 1'b0;
    end else begin
      stage_valid_q <= accept & req_i.need_rsp;
      rsp_valid_o   <= stage_valid_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      stage_rsp_q <= '{rdata: rsp_data, sid: req_i.sid, tid: req_i.tid};
    end
    rsp_o <= stage_rsp_q;
  end

endmodule

/* source/dcache_req_arbiter.sv */
module dcache_req_arbiter (
  input  logic                   load_valid_i,
  input  dcache_pkg::cache_req_t load_req_i,
  output logic                   load_ready_o,
  input  logic                   store_valid_i,
  input  dcache_pkg::cache_req_t store_req_i,
  output logic                   store_ready_o,
  output logic                   req_valid_o,
  output dcache_pkg::cache_req_t req_o,
  input  logic                   req_ready_i,
  input  logic                   rsp_valid_i,
  input  dcache_pkg::cache_rsp_t rsp_i,
  output logic                   rsp_valid_o,
  output dcache_pkg::cache_rsp_t rsp_o
);

  // Loads always win
  assign req_valid_o = load_valid_i | store_valid_i;

  always_comb begin
    if (load_valid_i) begin
      req_o = load_req_i;
    end else begin
      req_o = store_req_i;
    end
  end

  assign load_ready_o  = req_ready_i;
  // Store stream only gets the cache when no load is offered
  assign store_ready_o = req_ready_i & ~load_valid_i;

  // Both adapters see every response and filter on sid
  assign rsp_valid_o = rsp_valid_i;
  assign rsp_o       = rsp_i;

endmodule

/* source/store_amo_adapter.sv */
module store_amo_adapter (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   store_valid_i,
  input  dcache_pkg::store_req_t store_req_i,
  output logic                   store_ready_o,
  input  logic                   amo_req_valid_i,
  input  dcache_pkg::amo_req_t   amo_req_i,
  output logic                   amo_ack_o,
  output dcache_pkg::data_t      amo_result_o,
  output logic                   req_valid_o,
  input  logic                   req_ready_i,
  output dcache_pkg::cache_req_t req_o,
  input  logic                   rsp_valid_i,
  input  dcache_pkg::cache_rsp_t rsp_i
);

  dcache_pkg::cache_op_e amo_op;
  dcache_pkg::data_t     amo_wdata;
  dcache_pkg::be_t       amo_be;
  logic                  amo_is_word;
  logic                  amo_is_word_hi;
  logic [31:0]           amo_rsp_word;
  logic                  pending_q;
  logic                  pending_n;

  // Opcode translation
  always_comb begin
    unique case (amo_req_i.op)
      dcache_pkg::AMO_LR:   amo_op = dcache_pkg::CACHE_AMO_LR;
      dcache_pkg::AMO_SC:   amo_op = dcache_pkg::CACHE_AMO_SC;
      dcache_pkg::AMO_SWAP: amo_op = dcache_pkg::CACHE_AMO_SWAP;
      dcache_pkg::AMO_ADD:  amo_op = dcache_pkg::CACHE_AMO_ADD;
      dcache_pkg::AMO_AND:  amo_op = dcache_pkg::CACHE_AMO_AND;
      dcache_pkg::AMO_OR:   amo_op = dcache_pkg::CACHE_AMO_OR;
      dcache_pkg::AMO_XOR:  amo_op = dcache_pkg::CACHE_AMO_XOR;
      dcache_pkg::AMO_MAX:  amo_op = dcache_pkg::CACHE_AMO_MAX;
      dcache_pkg::AMO_MAXU: amo_op = dcache_pkg::CACHE_AMO_MAXU;
      dcache_pkg::AMO_MIN:  amo_op = dcache_pkg::CACHE_AMO_MIN;
      dcache_pkg::AMO_MINU: amo_op = dcache_pkg::CACHE_AMO_MINU;
      default:              amo_op = dcache_pkg::CACHE_LOAD;
    endcase
  end

  // Word operand goes to both lanes, the enables pick one
  assign amo_is_word    = (amo_req_i.size == dcache_pkg::SIZE_WORD);
  assign amo_is_word_hi = amo_req_i.operand_a[2];
  assign amo_wdata      = amo_is_word ? {2{amo_req_i.operand_b[31:0]}} : amo_req_i.operand_b;
  assign amo_be         = amo_is_word ? (amo_is_word_hi ? 8'hf0 : 8'h0f) : 8'hff;

  // A second AMO waits until the first one is acknowledged
  assign req_valid_o   = store_valid_i | (amo_req_valid_i & ~pending_q);
  assign store_ready_o = req_ready_i & ~amo_req_valid_i;

  always_comb begin
    req_o.sid = dcache_pkg::STORE_SID;
    if (amo_req_valid_i) begin
      req_o.offset   = amo_req_i.operand_a[dcache_pkg::OFFSET_LSB +: $bits(dcache_pkg::offset_t)];
      req_o.wdata    = amo_wdata;
      req_o.be       = amo_be;
      req_o.size     = amo_req_i.size;
      req_o.op       = amo_op;
      req_o.tid      = dcache_pkg::AMO_TID;
      req_o.need_rsp = 1'b1;
    end else begin
      req_o.offset   = store_req_i.addr[dcache_pkg::OFFSET_LSB +: $bits(dcache_pkg::offset_t)];
      req_o.wdata    = store_req_i.wdata;
      req_o.be       = store_req_i.be;
      req_o.size     = store_req_i.size;
      req_o.op       = dcache_pkg::CACHE_STORE;
      req_o.tid      = '0;
      req_o.need_rsp = 1'b0;
    end
  end

  // Ack is our sid with the reserved tid
  assign amo_ack_o = rsp_valid_i && (rsp_i.sid == dcache_pkg::STORE_SID)
                     && (rsp_i.tid == dcache_pkg::AMO_TID);

  assign amo_rsp_word = amo_is_word_hi ? rsp_i.rdata[63:32] : rsp_i.rdata[31:0];
  assign amo_result_o = amo_is_word ? {{32{amo_rsp_word[31]}}, amo_rsp_word} : rsp_i.rdata;

  // Pending from acceptance until the ack
  assign pending_n = (amo_req_valid_i & req_ready_i & ~pending_q) | (pending_q & ~amo_ack_o);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pending_q <= 1'b0;
    end else begin
      pending_q <= pending_n;
    end
  end

endmodule

/* source/load_port_adapter.sv */
module load_port_adapter (
  input  logic                   load_valid_i,
  input  dcache_pkg::load_req_t  load_req_i,
  output logic                   load_ready_o,
  output logic                   load_rsp_valid_o,
  output dcache_pkg::load_rsp_t  load_rsp_o,
  output logic                   req_valid_o,
  input  logic                   req_ready_i,
  output dcache_pkg::cache_req_t req_o,
  input  logic                   rsp_valid_i,
  input  dcache_pkg::cache_rsp_t rsp_i
);

  // Load requests go straight through with the core id
  assign req_valid_o  = load_valid_i;
  assign load_ready_o = req_ready_i;

  always_comb begin
    req_o.offset   = load_req_i.addr[dcache_pkg::OFFSET_LSB +: $bits(dcache_pkg::offset_t)];
    req_o.wdata    = '0;
    req_o.be       = load_req_i.be;
    req_o.size     = load_req_i.size;
    req_o.op       = dcache_pkg::CACHE_LOAD;
    req_o.sid      = dcache_pkg::LOAD_SID;
    req_o.tid      = load_req_i.tid;
    req_o.need_rsp = 1'b1;
  end

  // Only responses tagged with our own source id
  assign load_rsp_valid_o = rsp_valid_i && (rsp_i.sid == dcache_pkg::LOAD_SID);
  assign load_rsp_o.rdata = rsp_i.rdata;
  assign load_rsp_o.tid   = rsp_i.tid;

endmodule

/* source/dcache_pkg.sv */
package dcache_pkg;

  // Widths with a meaning of their own
  typedef logic [10:0] addr_t;
  typedef logic [7:0]  offset_t;
  typedef logic [63:0] data_t;
  typedef logic [7:0]  be_t;
  typedef logic [1:0]  size_t;
  typedef logic [3:0]  tid_t;
  typedef logic [0:0]  sid_t;

  localparam int unsigned NUM_LINES = 256;
  // Doubleword index starts above the byte-in-doubleword bits
  localparam int unsigned OFFSET_LSB = 3;
  localparam tid_t AMO_TID = '1;
  localparam sid_t LOAD_SID = 1'b0;
  localparam sid_t STORE_SID = 1'b1;
  // log2 of a 4-byte access
  localparam size_t SIZE_WORD = 2'd2;

  // Core-side atomic operations
  typedef enum logic [3:0] {
    AMO_LR, AMO_SC, AMO_SWAP, AMO_ADD, AMO_AND, AMO_OR,
    AMO_XOR, AMO_MAX, AMO_MAXU, AMO_MIN, AMO_MINU
  } amo_op_e;

  // Operations understood by the cache
  typedef enum logic [3:0] {
    CACHE_LOAD, CACHE_STORE, CACHE_AMO_LR, CACHE_AMO_SC, CACHE_AMO_SWAP,
    CACHE_AMO_ADD, CACHE_AMO_AND, CACHE_AMO_OR, CACHE_AMO_XOR,
    CACHE_AMO_MAX, CACHE_AMO_MAXU, CACHE_AMO_MIN, CACHE_AMO_MINU
  } cache_op_e;

  typedef struct packed {
    addr_t addr;
    size_t size;
    be_t   be;
    tid_t  tid;
  } load_req_t;

  typedef struct packed {
    data_t rdata;
    tid_t  tid;
  } load_rsp_t;

  typedef struct packed {
    addr_t addr;
    data_t wdata;
    be_t   be;
    size_t size;
  } store_req_t;

  typedef struct packed {
    amo_op_e op;
    size_t   size;
    addr_t   operand_a;
    data_t   operand_b;
  } amo_req_t;

  typedef struct packed {
    offset_t   offset;
    data_t     wdata;
    be_t       be;
    size_t     size;
    cache_op_e op;
    sid_t      sid;
    tid_t      tid;
    logic      need_rsp;
  } cache_req_t;

  typedef struct packed {
    data_t rdata;
    sid_t  sid;
    tid_t  tid;
  } cache_rsp_t;

endpackage
